//--- project.f
source/AesTypes.sv
source/AesTables.sv
source/AesInitialRound.sv
source/AesCipherRound.sv
source/AesFinalRound.sv
source/AesEncryptTop.sv
tests/AesRefModel.sv
tests/AesEncryptTb.sv

//--- Bender.yml
package:
  name: aes_encrypt

sources:
  - source/AesTypes.sv
  - source/AesTables.sv
  - source/AesInitialRound.sv
  - source/AesCipherRound.sv
  - source/AesFinalRound.sv
  - source/AesEncryptTop.sv
  - target: test
    files:
      - tests/AesRefModel.sv
      - tests/AesEncryptTb.sv

//--- tests/AesEncryptTb.sv
`default_nettype none
`timescale 1ns/10ps

module AesEncryptTb
    import AesTypes::*;
    import AesRefModel::*;
();

    localparam int LATENCY          = 11;
    localparam int RESET_CYCLES     = 16;
    localparam int NUM_BACK_TO_BACK = 200;
    localparam int NUM_GAPPED       = 200;
    // FIPS vector, random phases and four corner blocks
    localparam int NUM_SLOTS  = 1 + NUM_BACK_TO_BACK + NUM_GAPPED + 4;
    localparam int MAX_CYCLES = RESET_CYCLES + NUM_SLOTS + 2*LATENCY + 100;

    // FIPS-197 appendix C.1
    localparam key_t   FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam block_t FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic   clock;
    logic   rst;
    logic   inValid;
    block_t plaintext;
    key_t   key;
    logic   outValid;
    block_t ciphertext;

    integer               seed;
    int                   cycle = 0;
    logic [LATENCY-1:0]   validHist = '0;
    block_t               expected [$];

    AesEncryptTop i_AesEncryptTop (
        .clock      (clock),
        .rst        (rst),
        .inValid    (inValid),
        .plaintext  (plaintext),
        .key        (key),
        .outValid   (outValid),
        .ciphertext (ciphertext)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //********************************************************************
    // Error exits
    //********************************************************************

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic failCheck(input string msg);
        stopRun($sformatf("CHECK FAILED at %0t: %s", $time, msg));
    endtask

    //********************************************************************
    // Stimulus
    //********************************************************************

    function automatic block_t randomBlock();
        block_t b;
        for (int i = 0; i < 4; i++)
            b[4*i +: 4] = $random(seed);
        return b;
    endfunction

    // One accepted block with its expected result queued
    task automatic sendBlock(input block_t p, input key_t k, input block_t ct);
        @(posedge clock);
        inValid   <= 1'b1;
        plaintext <= p;
        key       <= k;
        expected.push_back(ct);
    endtask

    // Bubble with junk data
    task automatic sendIdle();
        @(posedge clock);
        inValid   <= 1'b0;
        plaintext <= randomBlock();
        key       <= randomBlock();
    endtask

    initial
    begin
        block_t p;
        key_t   k;
        seed      = 44565;
        rst       = 1'b1;
        // Valid held high through reset must not start any block
        inValid   = 1'b1;
        plaintext = '0;
        key       = '0;
        assert (encrypt(FIPS_PT, FIPS_KEY) === FIPS_CT)
        else
            failCheck("reference model disagrees with the FIPS-197 vector");
        repeat (RESET_CYCLES) @(posedge clock);
        rst     <= 1'b0;
        inValid <= 1'b0;
        // outValid stays low while only bubbles enter
        repeat (LATENCY) sendIdle();
        sendBlock(FIPS_PT, FIPS_KEY, FIPS_CT);
        // Full pipeline with a new key every cycle
        repeat (NUM_BACK_TO_BACK)
        begin
            p = randomBlock();
            k = randomBlock();
            sendBlock(p, k, encrypt(p, k));
        end
        // About 40 percent bubbles
        repeat (NUM_GAPPED)
        begin
            if ($unsigned($random(seed)) % 10 < 4)
                sendIdle();
            else
            begin
                p = randomBlock();
                k = randomBlock();
                sendBlock(p, k, encrypt(p, k));
            end
        end
        // Ends of the S-box
        sendBlock('0, '0, encrypt('0, '0));
        sendBlock('1, '1, encrypt('1, '1));
        sendBlock('0, '1, encrypt('0, '1));
        sendBlock('1, '0, encrypt('1, '0));
        repeat (LATENCY + 2) sendIdle();
        if (expected.size() == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
            stopRun($sformatf("%0d expected blocks never came out", expected.size()));
    end

    //********************************************************************
    // Output checker on the values from before this edge
    //********************************************************************

    always @(posedge clock)
    begin
        block_t want;
        cycle = cycle + 1;
        if (cycle > MAX_CYCLES)
            stopRun("Timeout: the run did not finish within the cycle limit");
        else
        begin
            // outValid is known from the second edge on
            if (cycle >= 2)
            begin
                assert (outValid === validHist[LATENCY-1])
                else
                    failCheck($sformatf("outValid is %b, expected %b",
                                        outValid, validHist[LATENCY-1]));
                if (validHist[LATENCY-1])
                begin
                    want = expected.pop_front();
                    assert (ciphertext === want)
                    else
                        failCheck($sformatf("ciphertext %h, expected %h", ciphertext, want));
                end
            end
            // The DUT accepts a block only outside reset
            validHist = {validHist[LATENCY-2:0], inValid && !rst};
        end
    end

endmodule

`default_nettype wire

//--- tests/AesRefModel.sv
`default_nettype none

// Behavioral AES-128 model for the testbench
// The S-box comes from the GF(2^8) inverse and the affine map, not from a table
package AesRefModel;

    // Product in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        // Shift and add, one bit of b at a time
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;
            x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};
        end
        return p;
    endfunction

    // Inverse as a^254, zero maps to zero
    function automatic logic [7:0] gfInv(input logic [7:0] a);
        logic [7:0] r;
        logic [7:0] sq;
        r  = 8'h01;
        sq = a;
        for (int i = 0; i < 8; i++)
        begin
            // 254 has bits 1 to 7 set
            if (i != 0)
                r = gfMul(r, sq);
            sq = gfMul(sq, sq);
        end
        return r;
    endfunction

    // Affine map on the inverse
    function automatic logic [7:0] sboxByte(input logic [7:0] a);
        logic [7:0] b;
        b = gfInv(a);
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                 ^ {b[3:0], b[7:4]} ^ 8'h63;
    endfunction

    //********************************************************************
    // Full encryption of one block
    //********************************************************************

    function automatic logic [127:0] encrypt(input logic [127:0] pt, input logic [127:0] key);
        logic [31:0]  w [44];
        logic [7:0]   s [4][4];
        logic [7:0]   t [4][4];
        logic [31:0]  tmp;
        logic [7:0]   rc;
        logic [127:0] ct;
        // Whole key schedule up front
        for (int i = 0; i < 4; i++)
            w[i] = key[127 - 32*i -: 32];
        rc = 8'h01;
        for (int i = 4; i < 44; i++)
        begin
            tmp = w[i-1];
            if (i % 4 == 0)
            begin
                // Rotate and substitute in one step
                tmp = {sboxByte(tmp[23:16]), sboxByte(tmp[15:8]),
                       sboxByte(tmp[7:0]), sboxByte(tmp[31:24])};
                tmp[31:24] = tmp[31:24] ^ rc;
                rc = gfMul(rc, 8'h02);
            end
            w[i] = w[i-4] ^ tmp;
        end
        // State as s[row][col], whitened by the first key
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                s[r][c] = pt[127 - 32*c - 8*r -: 8] ^ w[c][31 - 8*r -: 8];
        for (int round = 1; round <= 10; round++)
        begin
            // SubBytes, reading through the row shift
            for (int r = 0; r < 4; r++)
                for (int c = 0; c < 4; c++)
                    t[r][c] = sboxByte(s[r][(c + r) % 4]);
            for (int c = 0; c < 4; c++)
                for (int r = 0; r < 4; r++)
                begin
                    // No column mixing in round 10
                    if (round < 10)
                        s[r][c] = gfMul(t[r][c], 8'h02) ^ gfMul(t[(r+1)%4][c], 8'h03)
                                ^ t[(r+2)%4][c] ^ t[(r+3)%4][c];
                    else
                        s[r][c] = t[r][c];
                    s[r][c] = s[r][c] ^ w[4*round + c][31 - 8*r -: 8];
                end
        end
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                ct[127 - 32*c - 8*r -: 8] = s[r][c];
        return ct;
    endfunction

endpackage

`default_nettype wire

//--- source/AesEncryptTop.sv
`default_nettype none
`timescale 1ns/10ps

// Fully pipelined AES-128 encryption core
// One block with its own key may enter per cycle
// Eleven register stages from input to ciphertext
module AesEncryptTop
    import AesTypes::*;
(
    input  logic   clock,
    input  logic   rst,
    input  logic   inValid,
    input  block_t plaintext,
    input  key_t   key,
    output logic   outValid,
    output block_t ciphertext
);

    // Registered stage outputs
    // pipe[0] from the feeder, pipe[r] from cipher round r
    stage_t pipe [0:9];

    //********************************************************************
    // Feeder
    //********************************************************************

    AesInitialRound i_AesInitialRound (
        .clock     (clock),
        .rst       (rst),
        .inValid   (inValid),
        .plaintext (plaintext),
        .key       (key),
        .stageOut  (pipe[0])
    );

    //********************************************************************
    // Rounds 1 to 9
    //********************************************************************

    for (genvar r = 1; r <= 9; r++)
    begin : gRound
        AesCipherRound #(
            .ROUND (r)
        ) i_AesCipherRound (
            .clock    (clock),
            .rst      (rst),
            .stageIn  (pipe[r-1]),
            .stageOut (pipe[r])
        );
    end

    //********************************************************************
    // Drain, round 10
    //********************************************************************

    AesFinalRound i_AesFinalRound (
        .clock      (clock),
        .rst        (rst),
        .stageIn    (pipe[9]),
        .outValid   (outValid),
        .ciphertext (ciphertext)
    );

endmodule

`default_nettype wire

//--- source/AesFinalRound.sv
`default_nettype none
`timescale 1ns/10ps

// Last cipher round, no MixColumns
// Drains the pipeline into the output register
module AesFinalRound
    import AesTypes::*;
    import AesTables::*;
(
    input  logic   clock,
    input  logic   rst,
    input  stage_t stageIn,
    output logic   outValid,
    output block_t ciphertext
);

    // Round 10 uses the last round constant
    localparam int LAST_ROUND = 10;

    //********************************************************************
    // Round-10 key and transform
    //********************************************************************

    key_t   lastKey;
    block_t subbed;
    block_t shifted;
    block_t result;

    assign lastKey = keyStep(stageIn.roundKey, LAST_ROUND);

    // SubBytes and ShiftRows straight into AddRoundKey
    assign subbed  = subBytes(stageIn.state);
    assign shifted = shiftRows(subbed);
    assign result  = addRoundKey(shifted, lastKey);

    //********************************************************************
    // Output register
    //********************************************************************

    always_ff @(posedge clock)
    begin
        ciphertext <= result;

        // Pulses once per accepted block
        if (rst)
            outValid <= 1'b0;
        else
            outValid <= stageIn.valid;
    end

endmodule

`default_nettype wire

//--- source/AesCipherRound.sv
`default_nettype none
`timescale 1ns/10ps

// One full cipher round with its own key-schedule step
// The block's key travels with it, so each stage expands only its own round key
module AesCipherRound
    import AesTypes::*;
    import AesTables::*;
#(
    parameter int ROUND = 1     // 1 to 9, picks the round constant
)
(
    input  logic   clock,
    input  logic   rst,
    input  stage_t stageIn,
    output stage_t stageOut
);

    //********************************************************************
    // Key schedule step
    //********************************************************************

    key_t nextKey;

    // RotWord, SubWord and RCON on the last word, then chained
    assign nextKey = keyStep(stageIn.roundKey, ROUND);

    //********************************************************************
    // Round transform
    //********************************************************************

    block_t subbed;
    block_t shifted;
    block_t mixed;
    block_t nextState;

    assign subbed    = subBytes(stageIn.state);
    assign shifted   = shiftRows(subbed);
    assign mixed     = mixColumns(shifted);
    assign nextState = addRoundKey(mixed, nextKey);

    //********************************************************************
    // Stage register
    //********************************************************************

    always_ff @(posedge clock)
    begin
        stageOut.state    <= nextState;
        // Next stage derives its key from this one
        stageOut.roundKey <= nextKey;

        // Valid follows its data one stage down
        if (rst)
            stageOut.valid <= 1'b0;
        else
            stageOut.valid <= stageIn.valid;
    end

endmodule

`default_nettype wire

//--- source/AesInitialRound.sv
`default_nettype none
`timescale 1ns/10ps

// Pipeline feeder
// Whitens the plaintext with the cipher key and starts the key chain
module AesInitialRound
    import AesTypes::*;
    import AesTables::*;
(
    input  logic   clock,
    input  logic   rst,
    input  logic   inValid,
    input  block_t plaintext,
    input  key_t   key,
    output stage_t stageOut
);

    // Round 0 result
    block_t whitened;

    assign whitened = addRoundKey(plaintext, key);

    //********************************************************************
    // Stage register
    //********************************************************************

    always_ff @(posedge clock)
    begin
        // Payload
        stageOut.state    <= whitened;
        // Cipher key doubles as the round-0 key
        stageOut.roundKey <= key;

        // Bubbles enter when inValid is low
        if (rst)
            stageOut.valid <= 1'b0;
        else
            stageOut.valid <= inValid;
    end

endmodule

`default_nettype wire

//--- source/AesTables.sv
`default_nettype none

// Constant tables and round functions of AES-128 encryption
package AesTables;

    import AesTypes::*;

    //********************************************************************
    // Tables
    //********************************************************************

    // Forward S-box, indexed by the input byte
    localparam byte_t SBOX [256] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Round constants, one per key-schedule step
    localparam byte_t RCON [1:10] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    //********************************************************************
    // Word operations of the key schedule
    //********************************************************************

    // Cyclic left rotation by one byte
    function automatic word_t rotWord(input word_t w);
        return {w[1], w[2], w[3], w[0]};
    endfunction

    // S-box on each byte of a word
    function automatic word_t subWord(input word_t w);
        word_t r;
        for (int i = 0; i < 4; i++)
            r[i] = SBOX[w[i]];
        return r;
    endfunction

    // Next round key from the previous one
    function automatic key_t keyStep(input key_t prevKey, input int round);
        key_t  nextKey;
        word_t t;
        // Core on the last word
        t = subWord(rotWord(prevKey[12 +: 4]));
        t[0] = t[0] ^ RCON[round];
        nextKey[0 +: 4] = prevKey[0 +: 4] ^ t;
        // Chain through the remaining words
        for (int w = 1; w < 4; w++)
            nextKey[4*w +: 4] = prevKey[4*w +: 4] ^ nextKey[4*(w-1) +: 4];
        return nextKey;
    endfunction

    //********************************************************************
    // Block operations of the cipher rounds
    //********************************************************************

    function automatic block_t subBytes(input block_t s);
        block_t r;
        for (int i = 0; i < 16; i++)
            r[i] = SBOX[s[i]];
        return r;
    endfunction

    // Row r moves left by r columns
    function automatic block_t shiftRows(input block_t s);
        block_t r;
        for (int c = 0; c < 4; c++)
            for (int row = 0; row < 4; row++)
                r[4*c + row] = s[4*((c + row) % 4) + row];
        return r;
    endfunction

    // Multiply by x in GF(2^8)
    function automatic byte_t xTime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic block_t mixColumns(input block_t s);
        block_t r;
        byte_t  a0, a1, a2, a3;
        for (int c = 0; c < 4; c++)
        begin
            a0 = s[4*c];
            a1 = s[4*c + 1];
            a2 = s[4*c + 2];
            a3 = s[4*c + 3];
            // Fixed matrix 02 03 01 01, rotated per row
            r[4*c]     = xTime(a0) ^ xTime(a1) ^ a1 ^ a2 ^ a3;
            r[4*c + 1] = a0 ^ xTime(a1) ^ xTime(a2) ^ a2 ^ a3;
            r[4*c + 2] = a0 ^ a1 ^ xTime(a2) ^ xTime(a3) ^ a3;
            r[4*c + 3] = xTime(a0) ^ a0 ^ a1 ^ a2 ^ xTime(a3);
        end
        return r;
    endfunction

    function automatic block_t addRoundKey(input block_t s, input key_t k);
        return s ^ k;
    endfunction

endpackage

`default_nettype wire

//--- source/AesTypes.sv
`default_nettype none

// Shared data types of the AES-128 encryption pipeline
package AesTypes;

    // One byte of state or key
    typedef logic [7:0] byte_t;

    // One column of the state, or one key word
    typedef byte_t [0:3] word_t;

    // Sixteen bytes in column-major order, byte 0 is the MSB
    typedef byte_t [0:15] block_t;

    // Cipher key, laid out like a block
    typedef byte_t [0:15] key_t;

    // Bundle passed from one pipeline stage to the next
    typedef struct packed {
        logic   valid;
        block_t state;
        key_t   roundKey;   // Last round key applied to state
    } stage_t;

endpackage

`default_nettype wire
